/* design/isa_pkg.sv */
package isa_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------
    localparam int NB_REG   = 32;            // Data and instruction word
    localparam int NB_RADDR = 5;             // Register index
    localparam int NB_OP    = 6;             // Opcode and funct fields
    localparam int NB_IMM   = 16;            // Immediate field

    // Field positions, MIPS layout
    localparam int OPC_HI = 31;
    localparam int OPC_LO = 26;
    localparam int RS_HI  = 25;
    localparam int RS_LO  = 21;
    localparam int RT_HI  = 20;
    localparam int RT_LO  = 16;
    localparam int RD_HI  = 15;
    localparam int RD_LO  = 11;
    localparam int FN_HI  = 5;
    localparam int FN_LO  = 0;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [NB_OP-1:0] {
        OP_RTYPE = 6'h00,                    // Funct field selects the op
        OP_ADDIU = 6'h09,                    // Sign-extended imm
        OP_ANDI  = 6'h0C,                    // Zero-extended imm
        OP_ORI   = 6'h0D,                    // Zero-extended imm
        OP_HALT  = 6'h3F                     // Stops fetch
    } opcode_e;

    typedef enum logic [NB_OP-1:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A                      // Signed compare
    } funct_e;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    // ------------------------------
    // ALU operation carried in ID/EX
    // ------------------------------
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,                      // Wraps, no overflow trap
        ALU_SUB = 3'd1,                      // Wraps
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5                       // Signed less-than
    } alu_op_e;

    // ------------------------------
    // Operand source in execute
    // ------------------------------
    typedef enum logic {
        FWD_REG = 1'b0,                      // Value read in decode
        FWD_WB  = 1'b1                       // Bypass from EX/WB latch
    } fwd_sel_e;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int NB_IMEM_ADDR = 6                    // Word address width
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_clk_en,      // Pipeline step
    input  logic                       i_mem_we,      // Debug write strobe
    input  logic [NB_IMEM_ADDR-1:0]    i_mem_addr,    // Debug word address
    input  logic [isa_pkg::NB_REG-1:0] i_mem_data,    // Debug write word
    output logic [isa_pkg::NB_REG-1:0] o_instr,       // IF/ID instruction
    output logic                       o_halt_flag    // IF/ID halt marker
);
    import isa_pkg::*;

    localparam int IMEM_DEPTH = 2**NB_IMEM_ADDR;

    logic [NB_REG-1:0]       imem [IMEM_DEPTH];       // Instruction store
    logic [NB_IMEM_ADDR-1:0] pc;                      // Word-addressed PC
    logic                    halted;                  // HALT already fetched
    logic [NB_REG-1:0]       fetch_word;
    logic                    fetch_is_halt;

    assign fetch_word    = imem[pc];                  // Async read
    assign fetch_is_halt = (fetch_word[OPC_HI:OPC_LO] == OP_HALT);

    // Debug loader, independent of step enable
    always_ff @(posedge i_clk) begin
        if (i_mem_we) begin
            imem[i_mem_addr] <= i_mem_data;
        end
    end

    // ------------------------------
    // PC and IF/ID latch
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc          <= '0;
            halted      <= 1'b0;
            o_instr     <= '0;                        // All-zero word is a no-op
            o_halt_flag <= 1'b0;
        end else if (i_clk_en) begin
            if (halted) begin
                o_instr     <= '0;                    // Feed bubbles after HALT
                o_halt_flag <= 1'b0;
            end else begin
                o_instr     <= fetch_word;
                o_halt_flag <= fetch_is_halt;
                if (fetch_is_halt) begin
                    halted <= 1'b1;                   // PC frozen from here on
                end else begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

endmodule

/* design/control_decoder.sv */
`timescale 1ns/1ps

module control_decoder (
    input  isa_pkg::opcode_e  i_opcode,              // Instr [31:26]
    input  isa_pkg::funct_e   i_funct,               // Instr [5:0]
    output pipe_pkg::alu_op_e o_alu_op,
    output logic              o_alu_src_imm,         // Operand B from imm
    output logic              o_imm_zero_ext,        // Zero- vs sign-extend
    output logic              o_reg_dst_rd,          // Dest rd, else rt
    output logic              o_reg_write            // Result goes to regfile
);
    import isa_pkg::*;
    import pipe_pkg::*;

    always_comb begin
        o_alu_op       = ALU_ADD;                    // Defaults give a no-op
        o_alu_src_imm  = 1'b0;
        o_imm_zero_ext = 1'b0;
        o_reg_dst_rd   = 1'b0;
        o_reg_write    = 1'b0;

        case (i_opcode)
            OP_RTYPE: begin
                o_reg_dst_rd = 1'b1;
                o_reg_write  = 1'b1;
                case (i_funct)
                    FN_ADDU: o_alu_op = ALU_ADD;
                    FN_SUBU: o_alu_op = ALU_SUB;
                    FN_AND:  o_alu_op = ALU_AND;
                    FN_OR:   o_alu_op = ALU_OR;
                    FN_XOR:  o_alu_op = ALU_XOR;
                    FN_SLT:  o_alu_op = ALU_SLT;
                    default: o_reg_write = 1'b0;     // Unknown funct, no write
                endcase
            end
            OP_ADDIU: begin
                o_alu_op      = ALU_ADD;
                o_alu_src_imm = 1'b1;
                o_reg_write   = 1'b1;
            end
            OP_ANDI: begin
                o_alu_op       = ALU_AND;
                o_alu_src_imm  = 1'b1;
                o_imm_zero_ext = 1'b1;
                o_reg_write    = 1'b1;
            end
            OP_ORI: begin
                o_alu_op       = ALU_OR;
                o_alu_src_imm  = 1'b1;
                o_imm_zero_ext = 1'b1;
                o_reg_write    = 1'b1;
            end
            default: o_reg_write = 1'b0;             // HALT and unknown opcodes
        endcase
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_clk_en,
    input  logic [isa_pkg::NB_REG-1:0]   i_instr,       // From IF/ID
    input  logic                         i_halt_flag,
    input  logic                         i_wb_we,       // Write-back port
    input  logic [isa_pkg::NB_RADDR-1:0] i_wb_addr,
    input  logic [isa_pkg::NB_REG-1:0]   i_wb_data,
    input  logic [isa_pkg::NB_RADDR-1:0] i_dbg_addr,    // Debug read index
    output logic [isa_pkg::NB_REG-1:0]   o_dbg_data,
    output logic [isa_pkg::NB_REG-1:0]   o_rs_data,     // ID/EX outputs
    output logic [isa_pkg::NB_REG-1:0]   o_rt_data,
    output logic [isa_pkg::NB_REG-1:0]   o_imm,
    output logic [isa_pkg::NB_RADDR-1:0] o_rs_addr,
    output logic [isa_pkg::NB_RADDR-1:0] o_rt_addr,
    output logic [isa_pkg::NB_RADDR-1:0] o_dst_addr,
    output pipe_pkg::alu_op_e            o_alu_op,
    output logic                         o_alu_src_imm,
    output logic                         o_reg_write,
    output logic                         o_halt_flag
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [NB_REG-1:0]   regs [2**NB_RADDR];           // 32 x 32 register file
    logic [NB_RADDR-1:0] rs_addr, rt_addr, rd_addr;
    logic [NB_IMM-1:0]   imm_field;
    logic [NB_REG-1:0]   rs_data, rt_data, imm_ext;
    alu_op_e             ctl_alu_op;
    logic                ctl_alu_src_imm, ctl_imm_zero_ext, ctl_reg_dst_rd, ctl_reg_write;

    assign rs_addr   = i_instr[RS_HI:RS_LO];
    assign rt_addr   = i_instr[RT_HI:RT_LO];
    assign rd_addr   = i_instr[RD_HI:RD_LO];
    assign imm_field = i_instr[IMM_HI:IMM_LO];

    control_decoder u_control_decoder (
        .i_opcode       (opcode_e'(i_instr[OPC_HI:OPC_LO])),
        .i_funct        (funct_e'(i_instr[FN_HI:FN_LO])),
        .o_alu_op       (ctl_alu_op),
        .o_alu_src_imm  (ctl_alu_src_imm),
        .o_imm_zero_ext (ctl_imm_zero_ext),
        .o_reg_dst_rd   (ctl_reg_dst_rd),
        .o_reg_write    (ctl_reg_write)
    );

    // Read with write-first bypass, r0 tied low
    function automatic logic [NB_REG-1:0] read_reg(input logic [NB_RADDR-1:0] addr);
        logic [NB_REG-1:0] val;
        val = regs[addr];
        if (i_wb_we && (i_wb_addr == addr)) val = i_wb_data;
        if (addr == '0) val = '0;
        return val;
    endfunction

    always_comb begin
        rs_data    = read_reg(rs_addr);
        rt_data    = read_reg(rt_addr);
        o_dbg_data = (i_dbg_addr == '0) ? '0 : regs[i_dbg_addr];   // Debug port, no bypass
    end

    assign imm_ext = ctl_imm_zero_ext ? {{(NB_REG-NB_IMM){1'b0}}, imm_field}
                                      : {{(NB_REG-NB_IMM){imm_field[NB_IMM-1]}}, imm_field};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 2**NB_RADDR; i++) regs[i] <= '0;
        end else if (i_clk_en && i_wb_we && (i_wb_addr != '0)) begin
            regs[i_wb_addr] <= i_wb_data;                 // r0 ignores writes
        end
    end

    // ------------------------------
    // ID/EX latch
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_rs_addr     <= '0;
            o_rt_addr     <= '0;
            o_dst_addr    <= '0;
            o_alu_op      <= ALU_ADD;
            o_alu_src_imm <= 1'b0;
            o_reg_write   <= 1'b0;
            o_halt_flag   <= 1'b0;
        end else if (i_clk_en) begin
            o_rs_addr     <= rs_addr;
            o_rt_addr     <= rt_addr;
            o_dst_addr    <= ctl_reg_dst_rd ? rd_addr : rt_addr;
            o_alu_op      <= ctl_alu_op;
            o_alu_src_imm <= ctl_alu_src_imm;
            o_reg_write   <= ctl_reg_write;
            o_halt_flag   <= i_halt_flag;                 // Carried, never re-decoded
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clk_en) begin
            o_rs_data <= rs_data;                         // Operand payload
            o_rt_data <= rt_data;
            o_imm     <= imm_ext;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_clk_en,
    input  logic [isa_pkg::NB_REG-1:0]   i_rs_data,     // From ID/EX
    input  logic [isa_pkg::NB_REG-1:0]   i_rt_data,
    input  logic [isa_pkg::NB_REG-1:0]   i_imm,
    input  logic [isa_pkg::NB_RADDR-1:0] i_rs_addr,
    input  logic [isa_pkg::NB_RADDR-1:0] i_rt_addr,
    input  logic [isa_pkg::NB_RADDR-1:0] i_dst_addr,
    input  pipe_pkg::alu_op_e            i_alu_op,
    input  logic                         i_alu_src_imm,
    input  logic                         i_reg_write,
    input  logic                         i_halt_flag,
    output logic                         o_wb_we,       // EX/WB latch
    output logic [isa_pkg::NB_RADDR-1:0] o_wb_addr,
    output logic [isa_pkg::NB_REG-1:0]   o_wb_data,
    output logic                         o_halt         // Sticky until reset
);
    import isa_pkg::*;
    import pipe_pkg::*;

    fwd_sel_e          fwd_a, fwd_b;
    logic [NB_REG-1:0] op_a, op_rt, op_b;
    logic [NB_REG-1:0] alu_result;

    // ------------------------------
    // Forwarding from EX/WB
    // ------------------------------
    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (o_wb_we && (o_wb_addr != '0) && (o_wb_addr == i_rs_addr)) fwd_a = FWD_WB;
        if (o_wb_we && (o_wb_addr != '0) && (o_wb_addr == i_rt_addr)) fwd_b = FWD_WB;
    end

    assign op_a  = (fwd_a == FWD_WB) ? o_wb_data : i_rs_data;
    assign op_rt = (fwd_b == FWD_WB) ? o_wb_data : i_rt_data;
    assign op_b  = i_alu_src_imm ? i_imm : op_rt;            // Imm replaces rt

    // ALU
    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_result = op_a + op_b;               // Wraps mod 2^32
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(NB_REG-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = '0;
        endcase
    end

    // ------------------------------
    // EX/WB latch
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_we <= 1'b0;
            o_halt  <= 1'b0;
        end else if (i_clk_en) begin
            o_wb_we <= i_reg_write;
            o_halt  <= o_halt | i_halt_flag;                 // Holds once set
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_clk_en) begin
            o_wb_addr <= i_dst_addr;                         // Payload, qualified by we
            o_wb_data <= alu_result;
        end
    end

endmodule

/* design/pipeline_top.sv */
`timescale 1ns/1ps

module pipeline_top #(
    parameter int NB_IMEM_ADDR = 6                           // 64-word imem
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_dunit_clk_en,      // Global step
    input  logic                       i_dunit_w_mem,       // Imem write strobe
    input  logic [isa_pkg::NB_REG-1:0] i_dunit_addr,        // Imem and regfile index
    input  logic [isa_pkg::NB_REG-1:0] i_dunit_data_if,     // Imem write word
    output logic [isa_pkg::NB_REG-1:0] o_dunit_reg,         // Regfile read-back
    output logic                       o_halt
);
    import isa_pkg::*;
    import pipe_pkg::*;

    // IF/ID
    logic [NB_REG-1:0]   w_instr_ifid;
    logic                w_halt_ifid;
    // ID/EX
    logic [NB_REG-1:0]   w_rs_data_idex, w_rt_data_idex, w_imm_idex;
    logic [NB_RADDR-1:0] w_rs_addr_idex, w_rt_addr_idex, w_dst_addr_idex;
    alu_op_e             w_alu_op_idex;
    logic                w_alu_src_imm_idex, w_reg_write_idex, w_halt_idex;
    // EX/WB back to regfile
    logic                w_wb_we;
    logic [NB_RADDR-1:0] w_wb_addr;
    logic [NB_REG-1:0]   w_wb_data;

    fetch_unit #(
        .NB_IMEM_ADDR (NB_IMEM_ADDR)
    ) u_fetch_unit (
        .i_clk (i_clk), .i_rst (i_rst), .i_clk_en (i_dunit_clk_en),
        .i_mem_we    (i_dunit_w_mem),
        .i_mem_addr  (i_dunit_addr[NB_IMEM_ADDR-1:0]),      // Low bits only
        .i_mem_data  (i_dunit_data_if),
        .o_instr     (w_instr_ifid),
        .o_halt_flag (w_halt_ifid)
    );

    decode_stage u_decode_stage (
        .i_clk (i_clk), .i_rst (i_rst), .i_clk_en (i_dunit_clk_en),
        .i_instr (w_instr_ifid), .i_halt_flag (w_halt_ifid),
        .i_wb_we (w_wb_we), .i_wb_addr (w_wb_addr), .i_wb_data (w_wb_data),
        .i_dbg_addr    (i_dunit_addr[NB_RADDR-1:0]),
        .o_dbg_data    (o_dunit_reg),
        .o_rs_data     (w_rs_data_idex),  .o_rt_data  (w_rt_data_idex),
        .o_imm         (w_imm_idex),
        .o_rs_addr     (w_rs_addr_idex),  .o_rt_addr  (w_rt_addr_idex),
        .o_dst_addr    (w_dst_addr_idex), .o_alu_op   (w_alu_op_idex),
        .o_alu_src_imm (w_alu_src_imm_idex),
        .o_reg_write   (w_reg_write_idex),
        .o_halt_flag   (w_halt_idex)
    );

    execute_stage u_execute_stage (
        .i_clk (i_clk), .i_rst (i_rst), .i_clk_en (i_dunit_clk_en),
        .i_rs_data     (w_rs_data_idex),  .i_rt_data  (w_rt_data_idex),
        .i_imm         (w_imm_idex),
        .i_rs_addr     (w_rs_addr_idex),  .i_rt_addr  (w_rt_addr_idex),
        .i_dst_addr    (w_dst_addr_idex), .i_alu_op   (w_alu_op_idex),
        .i_alu_src_imm (w_alu_src_imm_idex),
        .i_reg_write   (w_reg_write_idex),
        .i_halt_flag   (w_halt_idex),
        .o_wb_we (w_wb_we), .o_wb_addr (w_wb_addr), .o_wb_data (w_wb_data),
        .o_halt  (o_halt)                                   // Latched halt, sticky
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,                // 40 ns clock
    parameter int RST_CYCLES     = 2
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD_NS o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);         // Sync reset seen twice
        @(negedge o_clk);
        o_rst = 1'b0;                                 // Released on falling edge
    end

endmodule

/* dv/tb_pipeline.sv */
`timescale 1ns/1ps

module tb_pipeline;
    import isa_pkg::*;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [4:0]  dst;                                 // Register the entry writes
        logic [31:0] expected;                            // Filled by the model
    } instr_t;

    localparam int MAX_INSTR = 32;

    logic        clk, rst;
    logic        i_dunit_clk_en, i_dunit_w_mem;
    logic [31:0] i_dunit_addr, i_dunit_data_if, o_dunit_reg;
    logic        o_halt;

    instr_t      prog [MAX_INSTR];
    int          n_instr, halt_idx;
    logic [31:0] exp_regs [32];

    tb_clock_gen u_tb_clock_gen (.o_clk(clk), .o_rst(rst));

    pipeline_top #(.NB_IMEM_ADDR(6)) u_pipeline_top (
        .i_clk (clk), .i_rst (rst), .i_dunit_clk_en (i_dunit_clk_en),
        .i_dunit_w_mem (i_dunit_w_mem), .i_dunit_addr (i_dunit_addr),
        .i_dunit_data_if (i_dunit_data_if), .o_dunit_reg (o_dunit_reg), .o_halt (o_halt)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic add_instr(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] rs,
                             input logic [4:0] rt, input logic [4:0] rd, input logic [15:0] imm);
        instr_t ins;
        ins = '{opcode: op, funct: fn, rs: rs, rt: rt, rd: rd, imm: imm, dst: rt, expected: '0};
        if (op == OP_RTYPE) ins.dst = rd;                 // I-type writes rt
        if (op == OP_HALT) ins.dst = '0;
        prog[n_instr] = ins;
        n_instr++;
    endtask

    function automatic logic [31:0] encode(input instr_t ins);
        if (ins.opcode == OP_RTYPE) return {ins.opcode, ins.rs, ins.rt, ins.rd, 5'd0, ins.funct};
        return {ins.opcode, ins.rs, ins.rt, ins.imm};
    endfunction

    // ------------------------------
    // Program, random operands
    // ------------------------------
    task automatic build_program();
        logic [31:0] rnd_a, rnd_b, rnd_c;
        rnd_a = $urandom;
        rnd_b = $urandom;
        rnd_c = $urandom;
        n_instr = 0;
        add_instr(OP_ADDIU, 6'h0, 5'd0, 5'd1, 5'd0, {1'b0, rnd_a[14:0]});   // Positive
        add_instr(OP_ADDIU, 6'h0, 5'd0, 5'd2, 5'd0, {1'b1, rnd_b[14:0]});   // Negative
        add_instr(OP_ANDI,  6'h0, 5'd2, 5'd3, 5'd0, 16'hF0F0);          // Zero-ext
        add_instr(OP_ORI,   6'h0, 5'd2, 5'd4, 5'd0, rnd_c[15:0]);       // Distance 2
        add_instr(OP_RTYPE, FN_ADDU, 5'd1, 5'd2, 5'd5, 16'h0);
        add_instr(OP_RTYPE, FN_SUBU, 5'd1, 5'd2, 5'd6, 16'h0);
        add_instr(OP_RTYPE, FN_AND,  5'd1, 5'd2, 5'd7, 16'h0);
        add_instr(OP_RTYPE, FN_OR,   5'd5, 5'd6, 5'd8, 16'h0);
        add_instr(OP_RTYPE, FN_XOR,  5'd8, 5'd7, 5'd9, 16'h0);         // Forward rs
        add_instr(OP_RTYPE, FN_SLT,  5'd2, 5'd1, 5'd10, 16'h0);        // Neg < pos
        add_instr(OP_RTYPE, FN_SLT,  5'd1, 5'd2, 5'd11, 16'h0);
        add_instr(OP_RTYPE, FN_ADDU, 5'd2, 5'd2, 5'd13, 16'h0);        // Wraps
        add_instr(OP_ADDIU, 6'h0, 5'd13, 5'd14, 5'd0, 16'h0001);
        add_instr(OP_RTYPE, FN_ADDU, 5'd14, 5'd14, 5'd15, 16'h0);      // Both forwarded
        add_instr(OP_RTYPE, FN_SUBU, 5'd15, 5'd14, 5'd16, 16'h0);
        add_instr(OP_ADDIU, 6'h0, 5'd1, 5'd0, 5'd0, 16'h1234);          // r0 write
        add_instr(OP_RTYPE, FN_ADDU, 5'd0, 5'd1, 5'd17, 16'h0);        // No r0 bypass
        add_instr(OP_RTYPE, FN_XOR,  5'd16, 5'd15, 5'd18, 16'h0);
        add_instr(OP_ORI,   6'h0, 5'd0, 5'd19, 5'd0, {1'b1, rnd_a[30:16]});   // Imm msb set
        add_instr(OP_RTYPE, FN_SLT,  5'd19, 5'd18, 5'd20, 16'h0);
        add_instr(OP_HALT,  6'h0, 5'd0, 5'd0, 5'd0, 16'h0);
        add_instr(OP_ADDIU, 6'h0, 5'd0, 5'd1, 5'd0, 16'h7777);          // Past HALT
        add_instr(OP_RTYPE, FN_ADDU, 5'd1, 5'd1, 5'd21, 16'h0);
        add_instr(OP_ORI,   6'h0, 5'd0, 5'd22, 5'd0, 16'hFFFF);
    endtask

    // Reference model, in program order until HALT
    task automatic run_model();
        logic [31:0] mregs [32];
        logic [31:0] a, b, res;
        for (int r = 0; r < 32; r++) mregs[r] = '0;
        halt_idx = -1;
        for (int i = 0; i < n_instr; i++) begin
            if (halt_idx < 0) begin
                a   = mregs[prog[i].rs];
                b   = mregs[prog[i].rt];
                res = '0;
                case (prog[i].opcode)
                    OP_ADDIU: res = a + {{16{prog[i].imm[15]}}, prog[i].imm};
                    OP_ANDI:  res = a & {16'h0, prog[i].imm};
                    OP_ORI:   res = a | {16'h0, prog[i].imm};
                    OP_HALT:  halt_idx = i;
                    OP_RTYPE: begin
                        case (prog[i].funct)
                            FN_ADDU: res = a + b;
                            FN_SUBU: res = a - b;
                            FN_AND:  res = a & b;
                            FN_OR:   res = a | b;
                            FN_XOR:  res = a ^ b;
                            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                            default: res = '0;
                        endcase
                    end
                    default: res = '0;
                endcase
                prog[i].expected = res;
                if (prog[i].dst != 5'd0) mregs[prog[i].dst] = res;   // r0 stays zero
            end
        end
        for (int r = 0; r < 32; r++) exp_regs[r] = '0;
        for (int i = 0; i < halt_idx; i++) begin
            if (prog[i].dst != 5'd0) exp_regs[prog[i].dst] = prog[i].expected;
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int en_edges, disabled, cycles, cycle_limit, stall_left, stall_budget;
        logic exp_halt;
        i_dunit_clk_en  = 1'b0;
        i_dunit_w_mem   = 1'b0;
        i_dunit_addr    = '0;
        i_dunit_data_if = '0;
        void'($urandom(32'h58fa_aade));
        build_program();
        run_model();
        cycle_limit  = 2 * n_instr + 20;
        stall_budget = 15;                                // Keeps run inside the limit
        stall_left   = 0;
        wait (rst == 1'b0);
        @(negedge clk);
        for (int i = 0; i < n_instr; i++) begin           // Debug loader
            i_dunit_w_mem   = 1'b1;
            i_dunit_addr    = i;
            i_dunit_data_if = encode(prog[i]);
            @(negedge clk);
        end
        i_dunit_w_mem = 1'b0;
        en_edges = 0;
        disabled = 0;
        cycles   = 0;
        while (o_halt !== 1'b1) begin
            assert (cycles < cycle_limit)
                else fail_now($sformatf("Timeout, o_halt never rose in %0d cycles", cycles));
            if (stall_left == 0 && stall_budget > 0 && ($urandom % 6) == 0) begin
                stall_left   = 1 + ($urandom % 4);
                stall_budget = stall_budget - stall_left;
            end
            if (en_edges == 10 && disabled == 0 && stall_left == 0) stall_left = 3;
            i_dunit_clk_en = (stall_left == 0);
            if (stall_left > 0) stall_left--;
            @(posedge clk);
            if (i_dunit_clk_en) en_edges++;
            else disabled++;
            cycles++;
            @(negedge clk);
            exp_halt = (en_edges >= halt_idx + 3);        // Rises after edge h+3
            assert (o_halt == exp_halt) else fail_now($sformatf(
                "ERR o_halt after %0d enabled edges: got 0x%h, expected 0x%h",
                en_edges, o_halt, exp_halt));
        end
        $display("o_halt after %0d enabled and %0d disabled cycles", en_edges, disabled);
        i_dunit_clk_en = 1'b1;
        repeat (2) begin                                  // Sticky halt, final write-back
            @(negedge clk);
            assert (o_halt == 1'b1) else fail_now($sformatf(
                "ERR o_halt after halt: got 0x%h, expected 0x%h", o_halt, 1'b1));
        end
        i_dunit_clk_en = 1'b0;
        for (int r = 0; r < 32; r++) begin                // Register read-back
            i_dunit_addr = r;
            @(posedge clk);
            assert (o_dunit_reg == exp_regs[r]) else fail_now($sformatf(
                "ERR o_dunit_reg r%0d: got 0x%h, expected 0x%h", r, o_dunit_reg, exp_regs[r]));
            @(negedge clk);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* sim.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/control_decoder.sv
design/decode_stage.sv
design/execute_stage.sv
design/pipeline_top.sv
dv/tb_clock_gen.sv
dv/tb_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pipeline
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= TESTBENCH FAILED
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended early, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
